// File: build.f
logic/mmio_misc_pkg.sv
logic/misc_regs.sv
logic/activity_stretch.sv
logic/led_select.sv
logic/mmio_misc_top.sv
sim/clock_gen.sv
sim/tb_mmio_misc.sv

// File: logic/activity_stretch.sv
`timescale 1ns/1ps

module activity_stretch #(
   parameter int stretch_cycles = 8
) (
   input  logic                               clk,
   input  logic                               reset,
   input  logic [1:mmio_misc_pkg::num_drives] drive_activity,
   output logic [1:mmio_misc_pkg::num_drives] activity
);

   localparam int cnt_width = $clog2(stretch_cycles + 1);

   logic [0:cnt_width-1] count [1:mmio_misc_pkg::num_drives];

   // A pulse reloads the full hold time, even in the middle of a hold
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i <= mmio_misc_pkg::num_drives; i++) begin
            count[i] <= '0;
         end
      end else begin
         for (int i = 1; i <= mmio_misc_pkg::num_drives; i++) begin
            if (drive_activity[i]) begin
               count[i] <= cnt_width'(stretch_cycles);
            end else if (count[i] != '0) begin
               count[i] <= count[i] - 1'b1;
            end
         end
      end
   end

   always_comb begin
      for (int i = 1; i <= mmio_misc_pkg::num_drives; i++) begin
         activity[i] = (count[i] != '0);
      end
   end

   for (genvar g = 1; g <= mmio_misc_pkg::num_drives; g++) begin : g_check
      a_count_bound: assert property (
         @(posedge clk) disable iff (reset)
         count[g] <= cnt_width'(stretch_cycles)
      );
   end

endmodule

// File: logic/led_select.sv
`timescale 1ns/1ps

module led_select (
   input  mmio_misc_pkg::led_cfg_t           cfg,
   input  mmio_misc_pkg::status_t            status,
   input  logic [1:mmio_misc_pkg::num_drives] activity,
   output mmio_misc_pkg::rgb_t               led1_rgb,
   output mmio_misc_pkg::rgb_t               led2_rgb,
   output mmio_misc_pkg::rgb_t               led3_rgb,
   output mmio_misc_pkg::rgb_t               led4_rgb
);

   mmio_misc_pkg::rgb_t       status_rgb;
   mmio_misc_pkg::led_mask_t  flags;
   mmio_misc_pkg::rgb_t [1:4] led_default;
   mmio_misc_pkg::rgb_t [1:4] led_out;
   logic [1:4]                led_on;

   // Red and green each light a full colour byte, blue stays off
   assign status_rgb.red   = {8{status.red}};
   assign status_rgb.green = {8{status.green}};
   assign status_rgb.blue  = 8'h00;

   // Flag 0 is always active so mask bit 0 forces the programmed colour
   assign flags = {1'b1, activity};

   // LEDs 1 and 2 mirror the board status, 3 and 4 are dark
   assign led_default[1] = status_rgb;
   assign led_default[2] = status_rgb;
   assign led_default[3] = '0;
   assign led_default[4] = '0;

   always_comb begin
      for (int i = 1; i <= 4; i++) begin
         led_on[i]  = |(cfg.mask[i] & flags);
         led_out[i] = led_on[i] ? cfg.value[i] : led_default[i];
      end
   end

   assign led1_rgb = led_out[1];
   assign led2_rgb = led_out[2];
   assign led3_rgb = led_out[3];
   assign led4_rgb = led_out[4];

endmodule

// File: logic/misc_regs.sv
`timescale 1ns/1ps

module misc_regs (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [0:3]              adr,
   input  logic                    cs,
   input  logic [0:3]              sel,
   input  logic                    we,
   input  logic [0:31]             d,
   output logic [0:31]             q,
   output mmio_misc_pkg::led_cfg_t cfg,
   output mmio_misc_pkg::status_t  status,
   output logic [0:4]              sw_reset
);

   mmio_misc_pkg::data_word_u      wr_word;
   mmio_misc_pkg::data_word_u      rd_word;
   mmio_misc_pkg::led_mask_t [1:4] led_mask;
   mmio_misc_pkg::rgb_t [1:4]      led_value;
   mmio_misc_pkg::status_t         status_reg;
   logic [0:4]                     sw_reset_reg;
   logic                           wr_en;

   // Whole-word writes are gated by the lowest byte lane
   assign wr_en   = cs && we && sel[3];
   assign wr_word = d;

   // Control and software reset registers
   always_ff @(posedge clk) begin
      if (reset) begin
         led_mask     <= '0;
         status_reg   <= '0;
         sw_reset_reg <= '1;
      end else if (wr_en) begin
         case (adr)
            mmio_misc_pkg::adr_ctrl: begin
               led_mask         <= wr_word.ctrl.mask;
               status_reg.red   <= wr_word.ctrl.red;
               status_reg.green <= wr_word.ctrl.green;
            end
            mmio_misc_pkg::adr_reset: begin
               sw_reset_reg <= wr_word.rst.sw_reset;
            end
            default: begin
            end
         endcase
      end
   end

   // The four LED colour registers
   always_ff @(posedge clk) begin
      if (wr_en) begin
         case (adr)
            mmio_misc_pkg::adr_led1: led_value[1] <= wr_word.led.color;
            mmio_misc_pkg::adr_led2: led_value[2] <= wr_word.led.color;
            mmio_misc_pkg::adr_led3: led_value[3] <= wr_word.led.color;
            mmio_misc_pkg::adr_led4: led_value[4] <= wr_word.led.color;
            default: begin
            end
         endcase
      end
   end

   // Read-back is decoded from the address alone and ignores cs
   always_comb begin
      rd_word = '0;
      case (adr)
         mmio_misc_pkg::adr_ctrl: begin
            rd_word.ctrl.mask  = led_mask;
            rd_word.ctrl.red   = status_reg.red;
            rd_word.ctrl.green = status_reg.green;
         end
         mmio_misc_pkg::adr_reset: begin
            rd_word.rst.sw_reset    = sw_reset_reg;
            rd_word.rst.reserved_lo = '1;
         end
         mmio_misc_pkg::adr_led1: rd_word.led.color = led_value[1];
         mmio_misc_pkg::adr_led2: rd_word.led.color = led_value[2];
         mmio_misc_pkg::adr_led3: rd_word.led.color = led_value[3];
         mmio_misc_pkg::adr_led4: rd_word.led.color = led_value[4];
         default: begin
         end
      endcase
   end

   assign q        = rd_word;
   assign cfg      = '{value: led_value, mask: led_mask};
   assign status   = status_reg;
   assign sw_reset = sw_reset_reg;

   // Unmapped addresses must read as zero
   a_unmapped_zero: assert property (
      @(posedge clk) disable iff (reset)
      (adr > mmio_misc_pkg::adr_led4) |-> (q == '0)
   );

endmodule

// File: logic/mmio_misc_pkg.sv
package mmio_misc_pkg;

   // Drive activity inputs feeding the LED enable flags
   localparam int num_drives = 3;

   // Register map, word addresses on the 4-bit bus
   localparam logic [0:3] adr_ctrl  = 4'h0;
   localparam logic [0:3] adr_reset = 4'h1;
   localparam logic [0:3] adr_led1  = 4'h2;
   localparam logic [0:3] adr_led2  = 4'h3;
   localparam logic [0:3] adr_led3  = 4'h4;
   localparam logic [0:3] adr_led4  = 4'h5;

   // Bit 0 is the most significant bit, as on the bus
   typedef struct packed {
      logic [0:7] red;
      logic [0:7] green;
      logic [0:7] blue;
   } rgb_t;

   // Bit 0 enables always, bits 1 to 3 follow drives 1 to 3
   typedef logic [0:3] led_mask_t;

   typedef struct packed {
      led_mask_t [1:4] mask;
      logic [0:13]     reserved;
      logic            red;
      logic            green;
   } ctrl_word_t;

   typedef struct packed {
      logic [0:7] reserved;
      rgb_t       color;
   } rgb_word_t;

   // The low three bits always read back as ones
   typedef struct packed {
      logic [0:23] reserved_hi;
      logic [0:4]  sw_reset;
      logic [0:2]  reserved_lo;
   } reset_word_t;

   // One bus word, decoded by address
   typedef union packed {
      ctrl_word_t  ctrl;
      reset_word_t rst;
      rgb_word_t   led;
   } data_word_u;

   typedef struct packed {
      rgb_t [1:4]      value;
      led_mask_t [1:4] mask;
   } led_cfg_t;

   typedef struct packed {
      logic red;
      logic green;
   } status_t;

endpackage

// File: logic/mmio_misc_top.sv
`timescale 1ns/1ps

module mmio_misc_top #(
   parameter int stretch_cycles = 8
) (
   input  logic                               clk,
   input  logic                               reset,
   input  logic [0:3]                         adr,
   input  logic                               cs,
   input  logic [0:3]                         sel,
   input  logic                               we,
   input  logic [0:31]                        d,
   input  logic [1:mmio_misc_pkg::num_drives] drive_activity,
   output logic [0:31]                        q,
   output logic [0:4]                         sw_reset,
   output mmio_misc_pkg::rgb_t                led1_rgb,
   output mmio_misc_pkg::rgb_t                led2_rgb,
   output mmio_misc_pkg::rgb_t                led3_rgb,
   output mmio_misc_pkg::rgb_t                led4_rgb
);

   mmio_misc_pkg::led_cfg_t            cfg;
   mmio_misc_pkg::status_t             status;
   logic [1:mmio_misc_pkg::num_drives] activity;

   misc_regs u_regs (
      .clk      (clk),
      .reset    (reset),
      .adr      (adr),
      .cs       (cs),
      .sel      (sel),
      .we       (we),
      .d        (d),
      .q        (q),
      .cfg      (cfg),
      .status   (status),
      .sw_reset (sw_reset)
   );

   activity_stretch #(
      .stretch_cycles (stretch_cycles)
   ) u_stretch (
      .clk            (clk),
      .reset          (reset),
      .drive_activity (drive_activity),
      .activity       (activity)
   );

   // Register settings and stretched activity meet here
   led_select u_select (
      .cfg      (cfg),
      .status   (status),
      .activity (activity),
      .led1_rgb (led1_rgb),
      .led2_rgb (led2_rgb),
      .led3_rgb (led3_rgb),
      .led4_rgb (led4_rgb)
   );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then judge the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f build.f --top-module tb_mmio_misc \
   -Mdir obj_dir -o sim_mmio_misc

./obj_dir/sim_mmio_misc | tee sim.log

if grep -q "Result: FAILED" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi
echo "Simulation passed"

// File: sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
   parameter int half_period  = 10,
   parameter int reset_cycles = 2
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // Reset drops on a falling edge, away from the edge where the DUT samples
   initial begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// File: sim/tb_mmio_misc.sv
`timescale 1ns/1ps

module tb_mmio_misc;

   localparam int stretch_cycles = 8;
   localparam int wait_limit     = 40;

   logic                clk;
   logic                reset;
   logic [0:3]          adr;
   logic                cs;
   logic [0:3]          sel;
   logic                we;
   logic [0:31]         d;
   logic [1:3]          drive_activity;
   logic [0:31]         q;
   logic [0:4]          sw_reset;
   mmio_misc_pkg::rgb_t led1_rgb;
   mmio_misc_pkg::rgb_t led2_rgb;
   mmio_misc_pkg::rgb_t led3_rgb;
   mmio_misc_pkg::rgb_t led4_rgb;

   // Shadow copy of the registers and the model of the activity counters
   mmio_misc_pkg::led_mask_t sh_mask [1:4];
   logic                     sh_red;
   logic                     sh_green;
   logic [0:4]               sh_sw_reset;
   mmio_misc_pkg::rgb_t      sh_value [1:4];
   logic [1:4]               sh_known = '0;
   int                       model_cnt [1:3];

   mmio_misc_pkg::rgb_t colours [1:4];
   string               test_name;
   int                  test_errors  = 0;
   int                  total_errors = 0;
   int                  tests_run    = 0;
   int                  tests_failed = 0;

   clock_gen u_clock (
      .clk   (clk),
      .reset (reset)
   );

   mmio_misc_top #(
      .stretch_cycles (stretch_cycles)
   ) u_dut (
      .clk            (clk),
      .reset          (reset),
      .adr            (adr),
      .cs             (cs),
      .sel            (sel),
      .we             (we),
      .d              (d),
      .drive_activity (drive_activity),
      .q              (q),
      .sw_reset       (sw_reset),
      .led1_rgb       (led1_rgb),
      .led2_rgb       (led2_rgb),
      .led3_rgb       (led3_rgb),
      .led4_rgb       (led4_rgb)
   );

   function automatic mmio_misc_pkg::rgb_t dut_led(input int n);
      case (n)
         1: return led1_rgb;
         2: return led2_rgb;
         3: return led3_rgb;
         default: return led4_rgb;
      endcase
   endfunction

   // Flag 0 is always set and flags 1 to 3 follow the modelled activity
   function automatic logic led_enabled(input int n);
      logic [0:3] flags;
      flags[0] = 1'b1;
      for (int i = 1; i <= 3; i++) begin
         flags[i] = (model_cnt[i] != 0);
      end
      return (sh_mask[n] & flags) != 4'b0000;
   endfunction

   function automatic mmio_misc_pkg::rgb_t expected_led(input int n);
      logic [0:23] status_rgb;
      status_rgb = {{8{sh_red}}, {8{sh_green}}, 8'h00};
      if (led_enabled(n)) begin
         return sh_value[n];
      end else if (n <= 2) begin
         return status_rgb;
      end
      return 24'h000000;
   endfunction

   function automatic logic [0:31] expected_q(input logic [0:3] a);
      logic [0:31] w;
      w = '0;
      case (a)
         4'h0: w = {sh_mask[1], sh_mask[2], sh_mask[3], sh_mask[4], 14'b0, sh_red, sh_green};
         4'h1: w = {24'h000000, sh_sw_reset, 3'b111};
         4'h2, 4'h3, 4'h4, 4'h5: w = {8'h00, sh_value[int'(a) - 1]};
         default: w = '0;
      endcase
      return w;
   endfunction

   task automatic report_mismatch(input string name, input logic [0:31] expected,
                                  input logic [0:31] actual);
      $display("[ERROR] time %0t: %s expected %h, got %h", $time, name, expected, actual);
      test_errors++;
   endtask

   task automatic compare_outputs();
      logic colour_adr;
      colour_adr = (adr >= 4'h2) && (adr <= 4'h5);
      if (!colour_adr || sh_known[int'(adr) - 1]) begin
         if (q !== expected_q(adr)) begin
            report_mismatch("q", expected_q(adr), q);
         end
      end
      if (sw_reset !== sh_sw_reset) begin
         report_mismatch("sw_reset", 32'(sh_sw_reset), 32'(sw_reset));
      end
      for (int n = 1; n <= 4; n++) begin
         if (sh_known[n] || !led_enabled(n)) begin
            if (dut_led(n) !== expected_led(n)) begin
               report_mismatch($sformatf("led%0d_rgb", n), 32'(expected_led(n)),
                               32'(dut_led(n)));
            end
         end
      end
   endtask

   // A write is accepted when cs, we and the lowest byte lane are all high
   task automatic apply_write();
      if (cs && we && sel[3]) begin
         case (adr)
            4'h0: begin
               sh_mask[1] = d[0:3];
               sh_mask[2] = d[4:7];
               sh_mask[3] = d[8:11];
               sh_mask[4] = d[12:15];
               sh_red     = d[30];
               sh_green   = d[31];
            end
            4'h1: sh_sw_reset = d[24:28];
            4'h2, 4'h3, 4'h4, 4'h5: begin
               sh_value[int'(adr) - 1] = d[8:31];
               sh_known[int'(adr) - 1] = 1'b1;
            end
            default: begin
            end
         endcase
      end
   endtask

   task automatic advance_activity();
      for (int i = 1; i <= 3; i++) begin
         if (drive_activity[i]) begin
            model_cnt[i] = stretch_cycles;
         end else if (model_cnt[i] > 0) begin
            model_cnt[i] = model_cnt[i] - 1;
         end
      end
   endtask

   // Outputs are compared with the state from before this edge, then the model steps
   always @(posedge clk) begin
      if (reset) begin
         sh_mask     = '{default: 4'b0000};
         sh_red      = 1'b0;
         sh_green    = 1'b0;
         sh_sw_reset = 5'b11111;
         model_cnt   = '{default: 0};
      end else begin
         compare_outputs();
         apply_write();
         advance_activity();
      end
   end

   task automatic bus_write(input logic [0:3] a, input logic [0:31] data,
                            input logic chip_sel, input logic [0:3] lanes);
      @(negedge clk);
      adr = a;
      d   = data;
      cs  = chip_sel;
      we  = 1'b1;
      sel = lanes;
      @(negedge clk);
      cs  = 1'b0;
      we  = 1'b0;
      sel = 4'h0;
   endtask

   task automatic read_word(input logic [0:3] a, output logic [0:31] data);
      @(negedge clk);
      adr = a;
      cs  = 1'b1;
      we  = 1'b0;
      @(posedge clk);
      data = q;
   endtask

   task automatic write_ctrl(input mmio_misc_pkg::led_mask_t [1:4] masks,
                             input logic red, input logic green);
      mmio_misc_pkg::data_word_u w;
      w            = '0;
      w.ctrl.mask  = masks;
      w.ctrl.red   = red;
      w.ctrl.green = green;
      bus_write(4'h0, w, 1'b1, 4'hf);
   endtask

   // Counts the falling edges at which LED n shows its colour after a pulse.
   // A nonzero second_at pulses the drive again at that falling edge.
   task automatic hold_measure(input int drv, input int n, input int second_at,
                               output int cycles);
      int   k;
      logic done;
      cycles = 0;
      k      = 0;
      done   = 1'b0;
      @(negedge clk);
      drive_activity[drv] = 1'b1;
      while (!done && k < wait_limit) begin
         @(negedge clk);
         k++;
         drive_activity[drv] = (k == second_at);
         if (dut_led(n) === colours[n]) begin
            cycles++;
         end else if (k > second_at) begin
            done = 1'b1;
         end
      end
      drive_activity[drv] = 1'b0;
      if (!done) begin
         $display("led%0d did not return to its default colour within %0d cycles",
                  n, wait_limit);
         test_errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors > 0) begin
         tests_failed++;
      end
      $display("Test %0d %s: %s, %0d errors", tests_run, test_name,
               (test_errors == 0) ? "ok" : "failing", test_errors);
   endtask

   initial begin
      logic [0:31]                    raw;
      logic [0:31]                    data;
      logic [0:23]                    want;
      logic [1:0]                     rg;
      mmio_misc_pkg::led_mask_t [1:4] masks;
      int                             cycles;
      int                             drv;
      int                             k;

      adr            = 4'h0;
      cs             = 1'b0;
      sel            = 4'h0;
      we             = 1'b0;
      d              = '0;
      drive_activity = '0;
      void'($urandom(32'hbadfad3c));

      // Edges compared right after reset count toward the first test
      start_test("reset state");
      k = 0;
      while (reset !== 1'b0 && k < wait_limit) begin
         @(negedge clk);
         k++;
      end
      if (reset !== 1'b0) begin
         $display("Reset was never released within %0d cycles", wait_limit);
         total_errors++;
      end

      read_word(4'h0, data);
      if (data !== 32'h00000000) report_mismatch("q at address 0", 32'h0, data);
      read_word(4'h1, data);
      if (data !== 32'h000000ff) report_mismatch("q at address 1", 32'hff, data);
      @(negedge clk);
      for (int n = 1; n <= 4; n++) begin
         if (dut_led(n) !== 24'h000000) begin
            report_mismatch($sformatf("led%0d_rgb", n), 32'h0, 32'(dut_led(n)));
         end
      end
      end_test();

      start_test("register read-back");
      for (int n = 1; n <= 4; n++) begin
         raw        = $urandom();
         colours[n] = raw[8:31];
         bus_write(4'(n + 1), raw, 1'b1, 4'hf);
      end
      for (int n = 1; n <= 4; n++) begin
         read_word(4'(n + 1), data);
         if (data !== {8'h00, colours[n]}) begin
            report_mismatch("q", {8'h00, colours[n]}, data);
         end
      end
      // Neither write below may land
      for (int n = 1; n <= 4; n++) begin
         raw = $urandom();
         bus_write(4'(n + 1), raw, 1'b1, {3'($urandom()), 1'b0});
         bus_write(4'(n + 1), ~raw, 1'b0, 4'hf);
         read_word(4'(n + 1), data);
         if (data !== {8'h00, colours[n]}) begin
            report_mismatch("q after ignored writes", {8'h00, colours[n]}, data);
         end
      end
      for (int a = 6; a <= 15; a++) begin
         read_word(4'(a), data);
         if (data !== 32'h0) report_mismatch($sformatf("q at address %0d", a), 32'h0, data);
      end
      end_test();

      start_test("status defaults");
      for (int s = 1; s <= 3; s++) begin
         rg = 2'(s);
         write_ctrl(16'h0000, rg[0], rg[1]);
         for (int n = 1; n <= 4; n++) begin
            want = (n <= 2) ? {{8{rg[0]}}, {8{rg[1]}}, 8'h00} : 24'h000000;
            if (dut_led(n) !== want) begin
               report_mismatch($sformatf("led%0d_rgb", n), 32'(want), 32'(dut_led(n)));
            end
         end
      end
      end_test();

      start_test("always enable");
      for (int n = 1; n <= 4; n++) begin
         masks    = '0;
         masks[n] = 4'b1000;
         write_ctrl(masks, 1'b1, 1'b1);
         for (int m = 1; m <= 4; m++) begin
            want = (m == n) ? colours[m] : ((m <= 2) ? 24'hffff00 : 24'h000000);
            if (dut_led(m) !== want) begin
               report_mismatch($sformatf("led%0d_rgb", m), 32'(want), 32'(dut_led(m)));
            end
         end
      end
      end_test();

      start_test("activity gating");
      for (int n = 1; n <= 4; n++) begin
         raw        = $urandom();
         raw[31]    = 1'b1;
         colours[n] = raw[8:31];
         bus_write(4'(n + 1), raw, 1'b1, 4'hf);
      end
      for (int n = 1; n <= 4; n++) begin
         drv           = ((n - 1) % 3) + 1;
         masks         = '0;
         masks[n][drv] = 1'b1;
         write_ctrl(masks, 1'b0, 1'b0);
         hold_measure(drv, n, 0, cycles);
         if (cycles != stretch_cycles) begin
            report_mismatch($sformatf("led%0d_rgb hold cycles", n), stretch_cycles, cycles);
         end
         hold_measure(drv, n, 3, cycles);
         if (cycles != 3 + stretch_cycles) begin
            report_mismatch($sformatf("led%0d_rgb retriggered hold cycles", n),
                            3 + stretch_cycles, cycles);
         end
      end
      end_test();

      start_test("software reset field");
      for (int i = 0; i < 8; i++) begin
         raw = $urandom();
         bus_write(4'h1, raw, 1'b1, 4'hf);
         if (sw_reset !== raw[24:28]) begin
            report_mismatch("sw_reset", 32'(raw[24:28]), 32'(sw_reset));
         end
         read_word(4'h1, data);
         if (data !== {24'h000000, raw[24:28], 3'b111}) begin
            report_mismatch("q at address 1", {24'h000000, raw[24:28], 3'b111}, data);
         end
      end
      end_test();

      $display("Summary: %0d tests, %0d failed, %0d errors",
               tests_run, tests_failed, total_errors);
      if (total_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
